//--- all.f
hw/fsab_spam_pkg.sv
hw/clear_csr_decode.sv
hw/clear_burst_planner.sv
hw/clear_beat_emitter.sv
hw/accel_clear.sv
test/fsab_sink_model.sv
test/tb_accel_clear.sv

//--- hw/accel_clear.sv
// Memory-clear accelerator top; single fsabi_clk domain, write-only on FSAB, credits limit bursts
`timescale 1ns/100ps

module accel_clear (
	input  logic                     fsabi_clk,
	input  logic                     fsabi_rst_b,
	input  fsab_spam_pkg::spam_req_t spam_req,
	input  logic                     fsab_credit,
	output fsab_spam_pkg::spam_rsp_t spam_rsp,
	output fsab_spam_pkg::fsab_req_t fsab_req
);
	import fsab_spam_pkg::*;

	cfg_wr_t                cfg_wr;
	burst_cmd_t             burst_cmd;
	logic [SPAM_DATA_W-1:0] datum;
	logic [FSAB_ADDR_W-1:0] lenrem;
	logic                   emit_ready;

	// Register decode
	clear_csr_decode i_csr_decode (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.spam_req    (spam_req),
		.lenrem      (lenrem),
		.spam_rsp    (spam_rsp),
		.cfg_wr      (cfg_wr),
		.datum       (datum)
	);

	// Credits and burst split
	clear_burst_planner i_burst_planner (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.cfg_wr      (cfg_wr),
		.fsab_credit (fsab_credit),
		.emit_ready  (emit_ready),
		.burst_cmd   (burst_cmd),
		.lenrem      (lenrem)
	);

	// Beats onto FSAB
	clear_beat_emitter i_beat_emitter (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.burst_cmd   (burst_cmd),
		.datum       (datum),
		.fsab_req    (fsab_req),
		.emit_ready  (emit_ready)
	);

endmodule

//--- hw/clear_beat_emitter.sv
// Write beats follow a start by one cycle and never stall; datum is sampled when the burst starts
`timescale 1ns/100ps

module clear_beat_emitter (
	input  logic                                  fsabi_clk,
	input  logic                                  fsabi_rst_b,
	input  fsab_spam_pkg::burst_cmd_t             burst_cmd,
	input  logic [fsab_spam_pkg::SPAM_DATA_W-1:0] datum,
	output fsab_spam_pkg::fsab_req_t              fsab_req,
	output logic                                  emit_ready
);
	import fsab_spam_pkg::*;

	logic                   valid_q;
	logic [FSAB_LEN_W-1:0]  beats_left;
	logic [FSAB_ADDR_W-1:0] addr_q;
	logic [FSAB_LEN_W-1:0]  len_q;
	logic [FSAB_DATA_W-1:0] data_q;

	// Beats still to come after the one on the bus now
	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			valid_q    <= 1'b0;
			beats_left <= '0;
		end else begin
			if (burst_cmd.start) begin
				valid_q    <= 1'b1;
				beats_left <= burst_cmd.len - 1'b1;
			end else if (beats_left != '0) begin
				beats_left <= beats_left - 1'b1;
			end else begin
				valid_q <= 1'b0;
			end
		end
	end

	// Every beat of a burst repeats the same header
	always_ff @(posedge fsabi_clk) begin
		if (burst_cmd.start) begin
			addr_q <= burst_cmd.addr;
			len_q  <= burst_cmd.len;
			data_q <= {datum, datum};
		end
	end

	// Idle or on the last beat, so the next burst can follow directly
	assign emit_ready = (beats_left == '0);

	assign fsab_req = '{
		valid:  valid_q,
		mode:   valid_q ? FSAB_WRITE : FSAB_NOP,
		did:    FSAB_DID_ACCEL,
		subdid: FSAB_SUBDID_CLEAR,
		addr:   addr_q,
		len:    len_q,
		data:   data_q,
		mask:   {FSAB_MASK_W{1'b1}}
	};

endmodule

//--- hw/clear_burst_planner.sv
// Splits the fill length into bursts of up to 8 beats; holds while credits are exhausted
`timescale 1ns/100ps

module clear_burst_planner (
	input  logic                                  fsabi_clk,
	input  logic                                  fsabi_rst_b,
	input  fsab_spam_pkg::cfg_wr_t                cfg_wr,
	input  logic                                  fsab_credit,
	input  logic                                  emit_ready,
	output fsab_spam_pkg::burst_cmd_t             burst_cmd,
	output logic [fsab_spam_pkg::FSAB_ADDR_W-1:0] lenrem
);
	import fsab_spam_pkg::*;

	logic [FSAB_ADDR_W-1:0]    addr_q;
	logic [FSAB_ADDR_W-1:0]    lenrem_q;
	logic [FSAB_CREDITS_W-1:0] credits;
	logic [FSAB_LEN_W-1:0]     burst_len;
	logic [FSAB_ADDR_W-1:0]    burst_bytes;
	logic                      cfg_busy;
	logic                      credit_avail;
	logic                      start;

	assign cfg_busy     = cfg_wr.addr_wr || cfg_wr.len_wr;
	assign credit_avail = (credits != '0);

	// min(lenrem, 8)
	assign burst_len = (lenrem_q > FSAB_ADDR_W'(FSAB_LEN_MAX)) ?
		FSAB_LEN_W'(FSAB_LEN_MAX) : lenrem_q[FSAB_LEN_W-1:0];

	// 8 bytes per beat
	assign burst_bytes = FSAB_ADDR_W'({burst_len, 3'b000});

	// Register writes block a start in the same cycle
	assign start = credit_avail && (lenrem_q != '0) && emit_ready && !cfg_busy;

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			addr_q   <= '0;
			lenrem_q <= '0;
		end else begin
			if (cfg_wr.addr_wr) begin
				addr_q <= cfg_wr.value;
			end else if (start) begin
				addr_q <= addr_q + burst_bytes;
			end

			if (cfg_wr.len_wr) begin
				lenrem_q <= cfg_wr.value;
			end else if (start) begin
				lenrem_q <= lenrem_q - FSAB_ADDR_W'(burst_len);
			end
		end
	end

	// Return and consume in one cycle cancel out
	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			credits <= FSAB_CREDITS_W'(FSAB_INITIAL_CREDITS);
		end else begin
			case ({fsab_credit, start})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign burst_cmd = '{
		start: start,
		addr:  addr_q,
		len:   burst_len
	};

	assign lenrem = lenrem_q;

endmodule

//--- hw/clear_csr_decode.sv
// SPAM decode on fsabi_clk only; ack one cycle after a match, unmapped offsets ack and read zero
`timescale 1ns/100ps

module clear_csr_decode (
	input  logic                                  fsabi_clk,
	input  logic                                  fsabi_rst_b,
	input  fsab_spam_pkg::spam_req_t              spam_req,
	input  logic [fsab_spam_pkg::FSAB_ADDR_W-1:0] lenrem,
	output fsab_spam_pkg::spam_rsp_t              spam_rsp,
	output fsab_spam_pkg::cfg_wr_t                cfg_wr,
	output logic [fsab_spam_pkg::SPAM_DATA_W-1:0] datum
);
	import fsab_spam_pkg::*;

	logic                   hit;
	logic                   wr_hit;
	logic                   rd_hit;
	csr_reg_e               offset;
	logic                   addr_wr_q;
	logic                   len_wr_q;
	logic [FSAB_ADDR_W-1:0] value_q;
	logic                   busy_b_q;
	logic [SPAM_DATA_W-1:0] rd_data_q;
	logic [SPAM_DATA_W-1:0] rd_data_nxt;

	// Device ID and prefix match
	assign hit = spam_req.valid &&
		(spam_req.did == SPAM_DID_ACCEL) &&
		((spam_req.addr & SPAM_ADDR_MASK) == SPAM_ADDR_PFX);

	assign wr_hit = hit && !spam_req.r_nw;
	assign rd_hit = hit && spam_req.r_nw;
	assign offset = csr_reg_e'(spam_req.addr[3:0]);

	// Only the length register is readable
	always_comb begin
		rd_data_nxt = '0;
		if (rd_hit) begin
			case (offset)
				CSR_LENREM: rd_data_nxt = {1'b0, lenrem};
				default:    rd_data_nxt = '0;
			endcase
		end
	end

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			busy_b_q  <= 1'b0;
			rd_data_q <= '0;
			addr_wr_q <= 1'b0;
			len_wr_q  <= 1'b0;
			datum     <= '0;
		end else begin
			busy_b_q  <= hit;
			rd_data_q <= rd_data_nxt;
			addr_wr_q <= wr_hit && (offset == CSR_ADDR);
			len_wr_q  <= wr_hit && (offset == CSR_LENREM);
			if (wr_hit && (offset == CSR_DATUM)) begin
				datum <= spam_req.data;
			end
		end
	end

	// Write value for the planner, qualified by the strobes
	always_ff @(posedge fsabi_clk) begin
		if (wr_hit) begin
			value_q <= spam_req.data[FSAB_ADDR_W-1:0];
		end
	end

	assign spam_rsp = '{
		busy_b: busy_b_q,
		data:   rd_data_q
	};

	assign cfg_wr = '{
		addr_wr: addr_wr_q,
		len_wr:  len_wr_q,
		value:   value_q
	};

endmodule

//--- hw/fsab_spam_pkg.sv
// Shared FSAB and SPAM widths, IDs, register map and bus structs; a single clock domain is assumed

package fsab_spam_pkg;

	// FSAB request side
	localparam int FSAB_ADDR_W          = 31;
	localparam int FSAB_LEN_W           = 4;
	localparam int FSAB_LEN_MAX         = 8;
	localparam int FSAB_DATA_W          = 64;
	localparam int FSAB_MASK_W          = 8;
	localparam int FSAB_DID_W           = 4;
	localparam int FSAB_CREDITS_W       = 3;
	localparam int FSAB_INITIAL_CREDITS = 4;

	// SPAM register bus
	localparam int SPAM_ADDR_W = 24;
	localparam int SPAM_DATA_W = 32;
	localparam int SPAM_DID_W  = 4;

	localparam logic [SPAM_DID_W-1:0]  SPAM_DID_ACCEL = 4'h3;
	localparam logic [SPAM_ADDR_W-1:0] SPAM_ADDR_PFX  = 24'h000000;
	localparam logic [SPAM_ADDR_W-1:0] SPAM_ADDR_MASK = 24'hF00000;

	// IDs stamped on every outgoing request
	localparam logic [FSAB_DID_W-1:0] FSAB_DID_ACCEL    = 4'h2;
	localparam logic [FSAB_DID_W-1:0] FSAB_SUBDID_CLEAR = 4'h1;

	typedef enum logic [1:0] {
		FSAB_NOP   = 2'd0,
		FSAB_READ  = 2'd1,
		FSAB_WRITE = 2'd2
	} fsab_mode_e;

	// Offsets in the low address nibble
	typedef enum logic [3:0] {
		CSR_DATUM  = 4'b0000,
		CSR_ADDR   = 4'b0100,
		CSR_LENREM = 4'b1000
	} csr_reg_e;

	typedef struct packed {
		logic                   valid;
		logic                   r_nw;
		logic [SPAM_DID_W-1:0]  did;
		logic [SPAM_ADDR_W-1:0] addr;
		logic [SPAM_DATA_W-1:0] data;
	} spam_req_t;

	// busy_b is a one-cycle acknowledge
	typedef struct packed {
		logic                   busy_b;
		logic [SPAM_DATA_W-1:0] data;
	} spam_rsp_t;

	// Value is shared by both strobes
	typedef struct packed {
		logic                   addr_wr;
		logic                   len_wr;
		logic [FSAB_ADDR_W-1:0] value;
	} cfg_wr_t;

	typedef struct packed {
		logic                   start;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0]  len;
	} burst_cmd_t;

	typedef struct packed {
		logic                   valid;
		fsab_mode_e             mode;
		logic [FSAB_DID_W-1:0]  did;
		logic [FSAB_DID_W-1:0]  subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0]  len;
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
	} fsab_req_t;

endpackage

//--- test/fsab_sink_model.sv
// FSAB memory model for simulation; logs up to 256 bursts and returns one credit per burst late
`timescale 1ns/100ps

module fsab_sink_model #(
	parameter int DELAY_MAX = 8
) (
	input  logic                     fsabi_clk,
	input  logic                     fsabi_rst_b,
	input  fsab_spam_pkg::fsab_req_t fsab_req,
	input  logic                     hold_credits,
	output logic                     fsab_credit
);
	import fsab_spam_pkg::*;

	fsab_req_t burst_log [0:255];
	fsab_req_t cur_hdr;
	int        beat_count = 0;
	int        burst_count = 0;
	int        credits_sent = 0;
	int        beats_in_burst = 0;
	int        wait_cnt = 1;
	integer    seed = 32'h038a_4d2c;
	logic      form_err = 1'b0;
	logic      credit_q = 1'b0;

	assign fsab_credit = credit_q;

	// Sampled on the falling edge, where the request is stable
	always @(negedge fsabi_clk) begin
		if (fsab_req.valid) begin
			if (beats_in_burst == 0) begin
				cur_hdr = fsab_req;
				if ((fsab_req.len == '0) || (fsab_req.len > FSAB_LEN_MAX)) begin
					form_err = 1'b1;
				end
			end else if (fsab_req != cur_hdr) begin
				// Header changed inside a burst
				form_err = 1'b1;
			end
			beats_in_burst = beats_in_burst + 1;
			beat_count = beat_count + 1;
			if (beats_in_burst == int'(cur_hdr.len)) begin
				burst_log[burst_count % 256] = cur_hdr;
				burst_count = burst_count + 1;
				beats_in_burst = 0;
			end
		end else if (beats_in_burst != 0) begin
			// Burst cut short
			form_err = 1'b1;
		end
	end

	// One credit per finished burst, each after 1 to DELAY_MAX cycles
	always @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			credit_q <= 1'b0;
		end else begin
			credit_q <= 1'b0;
			if (!hold_credits && (credits_sent < burst_count)) begin
				if (wait_cnt <= 1) begin
					credit_q     <= 1'b1;
					credits_sent <= credits_sent + 1;
					wait_cnt     <= 1 + ($unsigned($random(seed)) % DELAY_MAX);
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
		end
	end

endmodule

//--- test/tb_accel_clear.sv
// Directed tests for accel_clear on one 100 ns clock; the run stops at the first failed check
`timescale 1ns/100ps

module tb_accel_clear;
	import fsab_spam_pkg::*;

	localparam int RESET_CYCLES     = 10;
	localparam int CREDIT_DELAY_MAX = 8;
	localparam int STALL_CYCLES     = 24;
	// Cycle budget from all fills in the run
	localparam int TOTAL_PACKETS = 5 + 8 + 19 + 33 + 48 + 32 + 9 + 8;
	localparam int TOTAL_BURSTS  = 1 + 1 + 3 + 5 + 6 + 4 + 2 + 1;
	localparam int ACCESS_COUNT  = 40;
	localparam int CYCLE_LIMIT   = RESET_CYCLES + TOTAL_PACKETS +
		TOTAL_BURSTS * (CREDIT_DELAY_MAX + 2) + ACCESS_COUNT * 3 + 2 * STALL_CYCLES + 200;

	logic      fsabi_clk = 1'b0;
	logic      fsabi_rst_b = 1'b0;
	spam_req_t spam_req = '0;
	spam_rsp_t spam_rsp;
	fsab_req_t fsab_req;
	logic      fsab_credit;
	logic      hold_credits = 1'b0;
	int        cycle_count = 0;

	accel_clear i_accel_clear (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.spam_req    (spam_req),
		.fsab_credit (fsab_credit),
		.spam_rsp    (spam_rsp),
		.fsab_req    (fsab_req)
	);

	fsab_sink_model #(
		.DELAY_MAX (CREDIT_DELAY_MAX)
	) i_fsab_sink (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.fsab_req     (fsab_req),
		.hold_credits (hold_credits),
		.fsab_credit  (fsab_credit)
	);

	always #50 fsabi_clk = ~fsabi_clk;

	always @(posedge fsabi_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: tests still running after %0d cycles", cycle_count);
			$display("Checks failed");
			$fatal(1);
		end
	end

	task automatic check_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	// Request cycle, acknowledge cycle, quiet cycle
	task automatic spam_access(input logic r_nw, input logic [SPAM_DID_W-1:0] did,
		input logic [SPAM_ADDR_W-1:0] addr, input logic [SPAM_DATA_W-1:0] wdata,
		input logic ack_exp, output logic [SPAM_DATA_W-1:0] rdata);
		@(posedge fsabi_clk);
		spam_req <= '{valid: 1'b1, r_nw: r_nw, did: did, addr: addr, data: wdata};
		@(negedge fsabi_clk);
		check_value("busy_b in request cycle", spam_rsp.busy_b, 1'b0);
		@(posedge fsabi_clk);
		spam_req <= '0;
		@(negedge fsabi_clk);
		check_value("busy_b one cycle after request", spam_rsp.busy_b, ack_exp);
		rdata = spam_rsp.data;
		@(negedge fsabi_clk);
		check_value("busy_b two cycles after request", spam_rsp.busy_b, 1'b0);
		check_value("idle response data", spam_rsp.data, '0);
	endtask

	task automatic reg_write(input logic [3:0] offset, input logic [SPAM_DATA_W-1:0] value);
		logic [SPAM_DATA_W-1:0] rdata;
		spam_access(1'b0, SPAM_DID_ACCEL, {20'h00000, offset}, value, 1'b1, rdata);
	endtask

	task automatic reg_read_check(input logic [3:0] offset,
		input logic [SPAM_DATA_W-1:0] expected);
		logic [SPAM_DATA_W-1:0] rdata;
		spam_access(1'b1, SPAM_DID_ACCEL, {20'h00000, offset}, '0, 1'b1, rdata);
		check_value("register read data", rdata, expected);
	endtask

	task automatic wait_beats(input int target);
		do begin
			@(posedge fsabi_clk);
		end while (i_fsab_sink.beat_count < target);
	endtask

	task automatic wait_credits_home();
		do begin
			@(posedge fsabi_clk);
		end while (i_fsab_sink.credits_sent < i_fsab_sink.burst_count);
	endtask

	// Burst k covers packets 8k and up, at most eight of them
	task automatic check_bursts(input int first, input int n_pkts,
		input logic [FSAB_ADDR_W-1:0] start_addr, input logic [SPAM_DATA_W-1:0] datum);
		int        remaining;
		int        blen;
		int        k;
		fsab_req_t b;
		remaining = n_pkts;
		k = 0;
		while (remaining > 0) begin
			b = i_fsab_sink.burst_log[first + k];
			blen = (remaining > FSAB_LEN_MAX) ? FSAB_LEN_MAX : remaining;
			check_value("burst address", b.addr, start_addr + FSAB_ADDR_W'(64 * k));
			check_value("burst length", b.len, blen);
			check_value("burst data", b.data, {datum, datum});
			check_value("burst mask", b.mask, 8'hFF);
			check_value("burst mode", b.mode, FSAB_WRITE);
			check_value("burst did", b.did, FSAB_DID_ACCEL);
			check_value("burst subdid", b.subdid, FSAB_SUBDID_CLEAR);
			remaining = remaining - blen;
			k = k + 1;
		end
		check_value("burst count", i_fsab_sink.burst_count - first, k);
		check_value("malformed burst seen", i_fsab_sink.form_err, 1'b0);
	endtask

	task automatic run_fill(input logic [FSAB_ADDR_W-1:0] start_addr, input int n_pkts,
		input logic [SPAM_DATA_W-1:0] datum);
		int first_burst;
		int first_beat;
		@(posedge fsabi_clk);
		first_burst = i_fsab_sink.burst_count;
		first_beat = i_fsab_sink.beat_count;
		reg_write(CSR_DATUM, datum);
		reg_write(CSR_ADDR, {1'b0, start_addr});
		reg_write(CSR_LENREM, n_pkts);
		wait_beats(first_beat + n_pkts);
		wait_credits_home();
		check_value("beat count", i_fsab_sink.beat_count - first_beat, n_pkts);
		check_bursts(first_burst, n_pkts, start_addr, datum);
	endtask

	task automatic test_reset_ack();
		repeat (3) begin
			@(negedge fsabi_clk);
			check_value("fsab valid after reset", fsab_req.valid, 1'b0);
			check_value("busy_b after reset", spam_rsp.busy_b, 1'b0);
		end
		reg_write(CSR_DATUM, 32'h1234_5678);
	endtask

	task automatic test_fill_shapes();
		run_fill(31'h0000_1000, 5, 32'hDEAD_BEEF);
		run_fill(31'h0010_0000, 8, 32'h0F0F_A5A5);
		run_fill(31'h0123_4000, 19, 32'h5555_AAAA);
		run_fill(31'h7FFF_0000, 33, 32'hC001_D00D);
	endtask

	task automatic test_credit_limit();
		int first_burst;
		int first_beat;
		@(posedge fsabi_clk);
		first_burst = i_fsab_sink.burst_count;
		first_beat = i_fsab_sink.beat_count;
		hold_credits <= 1'b1;
		reg_write(CSR_DATUM, 32'h0BAD_F00D);
		reg_write(CSR_ADDR, 32'h0000_8000);
		reg_write(CSR_LENREM, 48);
		wait_beats(first_beat + FSAB_INITIAL_CREDITS * FSAB_LEN_MAX);
		// Planner must hold with every credit out
		repeat (STALL_CYCLES) @(posedge fsabi_clk);
		check_value("beats with credits held", i_fsab_sink.beat_count - first_beat, 32);
		reg_read_check(CSR_LENREM, 48 - 32);
		@(posedge fsabi_clk);
		hold_credits <= 1'b0;
		wait_beats(first_beat + 48);
		wait_credits_home();
		check_value("beats after credit return", i_fsab_sink.beat_count - first_beat, 48);
		check_bursts(first_burst, 48, 31'h0000_8000, 32'h0BAD_F00D);
	endtask

	task automatic test_lenrem_readback();
		int first_burst;
		int first_beat;
		@(posedge fsabi_clk);
		first_burst = i_fsab_sink.burst_count;
		first_beat = i_fsab_sink.beat_count;
		hold_credits <= 1'b1;
		reg_write(CSR_DATUM, 32'h3C3C_9696);
		reg_write(CSR_ADDR, 32'h0004_0000);
		reg_write(CSR_LENREM, 32);
		wait_beats(first_beat + 32);
		reg_write(CSR_LENREM, 32'hFFFF_FFFF);
		reg_read_check(CSR_LENREM, 32'h7FFF_FFFF);
		reg_read_check(CSR_DATUM, 32'h0);
		reg_read_check(CSR_ADDR, 32'h0);
		reg_read_check(4'hC, 32'h0);
		reg_write(CSR_LENREM, 0);
		@(posedge fsabi_clk);
		hold_credits <= 1'b0;
		wait_credits_home();
		check_value("beats after cancel", i_fsab_sink.beat_count - first_beat, 32);
		check_bursts(first_burst, 32, 31'h0004_0000, 32'h3C3C_9696);
	endtask

	task automatic test_bad_access_and_stop();
		logic [SPAM_DATA_W-1:0] rdata;
		int                     first_burst;
		int                     first_beat;
		run_fill(31'h0000_2000, 9, 32'h600D_CAFE);
		spam_access(1'b0, SPAM_DID_ACCEL ^ 4'h1, 24'h000008, 32'd9, 1'b0, rdata);
		spam_access(1'b0, SPAM_DID_ACCEL, 24'h100000, 32'hFFFF_FFFF, 1'b0, rdata);
		spam_access(1'b1, 4'h0, 24'h000008, '0, 1'b0, rdata);
		check_value("read data without ack", rdata, 32'h0);
		reg_read_check(CSR_LENREM, 32'h0);

		// Cancel while the first burst is on the bus
		@(posedge fsabi_clk);
		first_burst = i_fsab_sink.burst_count;
		first_beat = i_fsab_sink.beat_count;
		reg_write(CSR_ADDR, 32'h0000_3000);
		reg_write(CSR_LENREM, 40);
		wait_beats(first_beat + 2);
		reg_write(CSR_LENREM, 0);
		wait_credits_home();
		repeat (STALL_CYCLES) @(posedge fsabi_clk);
		check_value("beats after stop", i_fsab_sink.beat_count - first_beat, 8);
		check_bursts(first_burst, 8, 31'h0000_3000, 32'h600D_CAFE);
		reg_read_check(CSR_LENREM, 32'h0);
	endtask

	initial begin
		repeat (RESET_CYCLES) @(posedge fsabi_clk);
		fsabi_rst_b <= 1'b1;
		test_reset_ack();
		test_fill_shapes();
		test_credit_limit();
		test_lenrem_readback();
		test_bad_access_and_stop();
		$display("All checks passed");
		$finish;
	end

endmodule
